/* rtl/cnn_pkg.sv */
package cnn_pkg;

    localparam int DATA_W    = 32;
    localparam int KERNEL    = 5;               // window side
    localparam int TAPS      = KERNEL * KERNEL;
    localparam int N_KERNELS = 6;
    localparam int N_WEIGHTS = TAPS * N_KERNELS; // length of the weight stream

    // pixels and results share one signed format
    typedef logic signed [DATA_W-1:0] pixel_t;

    // tap j sits at window row j/KERNEL, column j%KERNEL, row 0 oldest
    typedef pixel_t [TAPS-1:0] taps_t;

    // bit j of a kernel word weights tap j, 1 adds and 0 subtracts
    typedef logic [TAPS-1:0] kernel_w_t;

endpackage

/* rtl/cnn_ctrl.sv */
`timescale 1ns/1ps

module cnn_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic start_cnn,
    input  logic weight_tvalid,
    input  logic image_tvalid,
    input  logic weights_full,
    input  logic last_pixel,
    input  logic window_valid,
    input  logic busy,
    output logic weight_tready,
    output logic image_tready,
    output logic weight_take,
    output logic pixel_take,
    output logic conv_start,
    output logic load,
    output logic cnn_done,
    output logic clear
);

    typedef enum logic [2:0] {idle, load_w, run, wait_res, done} state_t;

    state_t state;
    state_t state_nxt;
    logic   start_d;
    logic   start_edge;
    logic   last_seen;  // final pixel already taken
    logic   drained;    // nothing left in the conv pipe or the serializer

    assign start_edge = start_cnn && !start_d;
    assign clear      = (state == idle) && start_edge;
    assign drained    = !conv_start && !load && !busy;

    assign weight_tready = (state == load_w) && !weights_full;
    assign image_tready  = (state == run);
    assign weight_take   = weight_tvalid && weight_tready;
    assign pixel_take    = image_tvalid && image_tready;
    assign cnn_done      = (state == wait_res) && drained && last_seen;

    always_comb begin
        state_nxt = state;
        case (state)
            idle:     if (start_edge) state_nxt = load_w;
            load_w:   if (weights_full) state_nxt = run;
            run:      if (window_valid) state_nxt = wait_res;
            wait_res: begin
                if (drained) begin
                    if (last_seen)
                        state_nxt = done;
                    else
                        state_nxt = run;
                end
            end
            done:     state_nxt = idle; // one guard cycle, start still ignored
            default:  state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= idle;
            start_d    <= 1'b0;
            last_seen  <= 1'b0;
            conv_start <= 1'b0;
            load       <= 1'b0;
        end else begin
            state      <= state_nxt;
            start_d    <= start_cnn;
            conv_start <= window_valid;  // taps settle one cycle after the accept
            load       <= conv_start;
            if (clear)
                last_seen <= 1'b0;
            else if (pixel_take && last_pixel)
                last_seen <= 1'b1;
        end
    end

    // only one window may be in flight through kernels and serializer
    a_one_window: assert property (@(posedge clk) disable iff (!rstn)
        pixel_take |-> !conv_start && !load && !busy);

endmodule

/* rtl/cnn_counter.sv */
`timescale 1ns/1ps

module cnn_counter #(
    parameter int IMG_W = 28
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       clear,
    input  logic       weight_take,
    input  logic       pixel_take,
    output logic [7:0] weight_idx,
    output logic       weights_full,
    output logic       window_valid,
    output logic       last_pixel
);

    localparam int CW = $clog2(IMG_W);

    logic [CW-1:0] col;
    logic [CW-1:0] row;
    logic          col_end;
    logic          row_end;

    assign col_end = (col == CW'(IMG_W - 1));
    assign row_end = (row == CW'(IMG_W - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            weight_idx <= '0;
            col        <= '0;
            row        <= '0;
        end else if (clear) begin
            weight_idx <= '0;
            col        <= '0;
            row        <= '0;
        end else begin
            if (weight_take)
                weight_idx <= weight_idx + 8'd1;
            if (pixel_take) begin
                col <= col_end ? '0 : col + 1'b1;
                if (col_end)
                    row <= row_end ? '0 : row + 1'b1;
            end
        end
    end

    assign weights_full = (weight_idx == 8'(cnn_pkg::N_WEIGHTS));

    // strobes, only during an accept
    assign window_valid = pixel_take && (row >= CW'(cnn_pkg::KERNEL - 1))
                          && (col >= CW'(cnn_pkg::KERNEL - 1));
    assign last_pixel   = pixel_take && row_end && col_end;

endmodule

/* rtl/weight_bank.sv */
`timescale 1ns/1ps

module weight_bank (
    input  logic               clk,
    input  logic               rstn,
    input  logic               weight_take,
    input  logic [7:0]         weight_idx,
    input  logic               weight_tdata,
    output cnn_pkg::kernel_w_t kernel_w [cnn_pkg::N_KERNELS]
);

    logic [2:0] k_sel;  // which kernel
    logic [4:0] b_sel;  // which tap inside it

    // 25 consecutive bits per kernel, kernel 0 first
    assign k_sel = 3'(weight_idx / cnn_pkg::TAPS);
    assign b_sel = 5'(weight_idx % cnn_pkg::TAPS);

    always_ff @(posedge clk) begin
        if (weight_take)
            kernel_w[k_sel][b_sel] <= weight_tdata;
    end

    a_idx_range: assert property (@(posedge clk) disable iff (!rstn)
        weight_take |-> weight_idx < 8'(cnn_pkg::N_WEIGHTS));

endmodule

/* rtl/line_window.sv */
`timescale 1ns/1ps

module line_window #(
    parameter int IMG_W = 28
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            pixel_take,
    input  cnn_pkg::pixel_t image_tdata,
    output cnn_pkg::taps_t  taps
);

    localparam int K = cnn_pkg::KERNEL;

    // line_q[0] delays by one row, line_q[K-2] by four rows
    cnn_pkg::pixel_t line_q  [K-1][IMG_W];
    cnn_pkg::pixel_t win     [K][K];
    cnn_pkg::pixel_t new_col [K];

    always_ff @(posedge clk) begin
        if (pixel_take) begin
            line_q[0][0] <= image_tdata;
            for (int l = 1; l < K - 1; l++)
                line_q[l][0] <= line_q[l-1][IMG_W-1];  // cascade row to row
            for (int l = 0; l < K - 1; l++) begin
                for (int i = 1; i < IMG_W; i++)
                    line_q[l][i] <= line_q[l][i-1];
            end
        end
    end

    // incoming column, bottom row is the live pixel
    always_comb begin
        new_col[K-1] = image_tdata;
        for (int l = 0; l < K - 1; l++)
            new_col[K-2-l] = line_q[l][IMG_W-1];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K; c++)
                    win[r][c] <= '0;
            end
        end else if (pixel_take) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K - 1; c++)
                    win[r][c] <= win[r][c+1];  // oldest column drops out at 0
                win[r][K-1] <= new_col[r];
            end
        end
    end

    always_comb begin
        for (int r = 0; r < K; r++) begin
            for (int c = 0; c < K; c++)
                taps[r*K + c] = win[r][c];
        end
    end

endmodule

/* rtl/conv_kernel.sv */
`timescale 1ns/1ps

module conv_kernel (
    input  logic               clk,
    input  logic               rstn,
    input  logic               conv_start,
    input  cnn_pkg::taps_t     taps,
    input  cnn_pkg::kernel_w_t kernel_w,
    output cnn_pkg::pixel_t    sum
);

    cnn_pkg::pixel_t acc;

    // binary weights, so no multipliers, just add or subtract
    always_comb begin
        acc = '0;
        for (int j = 0; j < cnn_pkg::TAPS; j++) begin
            if (kernel_w[j])
                acc = acc + taps[j];
            else
                acc = acc - taps[j];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            sum <= '0;
        else if (conv_start)
            sum <= acc;  // wraps at 32 bits
    end

endmodule

/* rtl/result_serializer.sv */
`timescale 1ns/1ps

module result_serializer (
    input  logic            clk,
    input  logic            rstn,
    input  logic            load,
    input  cnn_pkg::pixel_t sums [cnn_pkg::N_KERNELS],
    output logic            result_tvalid,
    output cnn_pkg::pixel_t result_tdata,
    output logic            busy
);

    cnn_pkg::pixel_t hold [cnn_pkg::N_KERNELS];
    logic [2:0]      idx;  // kernel currently on the port

    always_ff @(posedge clk) begin
        if (load)
            hold <= sums;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (load) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (busy) begin
            if (idx == 3'(cnn_pkg::N_KERNELS - 1)) begin
                busy <= 1'b0;
                idx  <= '0;
            end else begin
                idx <= idx + 3'd1;
            end
        end
    end

    assign result_tvalid = busy;
    assign result_tdata  = hold[idx];

    a_no_overrun: assert property (@(posedge clk) disable iff (!rstn) load |-> !busy);

endmodule

/* rtl/cnn_top.sv */
`timescale 1ns/1ps

module cnn_top #(
    parameter int IMG_W = 28
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            start_cnn,
    input  logic            image_tvalid,
    input  cnn_pkg::pixel_t image_tdata,
    output logic            image_tready,
    input  logic            weight_tvalid,
    input  logic            weight_tdata,
    output logic            weight_tready,
    output logic            cnn_done,
    output logic            result_tvalid,
    output cnn_pkg::pixel_t result_tdata
);

    logic               weight_take;
    logic               pixel_take;
    logic               clear;
    logic               weights_full;
    logic               window_valid;
    logic               last_pixel;
    logic               conv_start;
    logic               load;
    logic               busy;
    logic [7:0]         weight_idx;
    cnn_pkg::kernel_w_t kernel_w [cnn_pkg::N_KERNELS];
    cnn_pkg::taps_t     taps;
    cnn_pkg::pixel_t    sums [cnn_pkg::N_KERNELS];

    cnn_ctrl ctrl_i (
        .clk           (clk),
        .rstn          (rstn),
        .start_cnn     (start_cnn),
        .weight_tvalid (weight_tvalid),
        .image_tvalid  (image_tvalid),
        .weights_full  (weights_full),
        .last_pixel    (last_pixel),
        .window_valid  (window_valid),
        .busy          (busy),
        .weight_tready (weight_tready),
        .image_tready  (image_tready),
        .weight_take   (weight_take),
        .pixel_take    (pixel_take),
        .conv_start    (conv_start),
        .load          (load),
        .cnn_done      (cnn_done),
        .clear         (clear)
    );

    cnn_counter #(.IMG_W(IMG_W)) counter_i (
        .clk          (clk),
        .rstn         (rstn),
        .clear        (clear),
        .weight_take  (weight_take),
        .pixel_take   (pixel_take),
        .weight_idx   (weight_idx),
        .weights_full (weights_full),
        .window_valid (window_valid),
        .last_pixel   (last_pixel)
    );

    weight_bank wbank_i (
        .clk          (clk),
        .rstn         (rstn),
        .weight_take  (weight_take),
        .weight_idx   (weight_idx),
        .weight_tdata (weight_tdata),
        .kernel_w     (kernel_w)
    );

    line_window #(.IMG_W(IMG_W)) window_i (
        .clk         (clk),
        .rstn        (rstn),
        .pixel_take  (pixel_take),
        .image_tdata (image_tdata),
        .taps        (taps)
    );

    // all six engines see the same window
    for (genvar k = 0; k < cnn_pkg::N_KERNELS; k++) begin : g_conv
        conv_kernel conv_i (
            .clk        (clk),
            .rstn       (rstn),
            .conv_start (conv_start),
            .taps       (taps),
            .kernel_w   (kernel_w[k]),
            .sum        (sums[k])
        );
    end

    result_serializer ser_i (
        .clk           (clk),
        .rstn          (rstn),
        .load          (load),
        .sums          (sums),
        .result_tvalid (result_tvalid),
        .result_tdata  (result_tdata),
        .busy          (busy)
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #2 clk = ~clk;  // 4 ns period

endmodule

/* testbench/tb_cnn.sv */
`timescale 1ns/1ps

module tb_cnn;

    localparam int IMG_W    = 6;
    localparam int N_KERN   = cnn_pkg::N_KERNELS;
    localparam int N_W      = cnn_pkg::N_WEIGHTS;
    localparam int N_PIX    = IMG_W * IMG_W;
    localparam int N_WIN    = (IMG_W - cnn_pkg::KERNEL + 1) ** 2;
    localparam int N_RES    = N_WIN * N_KERN;
    localparam int EXP_BASE = N_KERN + N_PIX;  // first expected result in the pattern memory
    localparam int N_WORDS  = EXP_BASE + N_RES;
    localparam int AW       = $clog2(N_WORDS);
    localparam int LIMIT    = (N_W + N_PIX + N_WIN * 10) * 2 + 100;

    logic            clk;
    logic            rstn;
    logic            start_cnn;
    logic            image_tvalid;
    cnn_pkg::pixel_t image_tdata;
    logic            image_tready;
    logic            weight_tvalid;
    logic            weight_tdata;
    logic            weight_tready;
    logic            cnn_done;
    logic            result_tvalid;
    cnn_pkg::pixel_t result_tdata;

    logic [31:0] pattern [N_WORDS];
    integer      seed;
    int          run_no     = 0;  // bumped by the stimulus before each start
    int          seen_run   = 0;
    int          w_count    = 0;
    int          res_count  = 0;
    int          res_total  = 0;
    int          burst      = 0;  // valid cycles of the current window
    int          done_count = 0;
    int          errors     = 0;
    int          cycles     = 0;

    tb_clock clk_gen_i (.clk(clk));

    cnn_top #(.IMG_W(IMG_W)) dut_i (
        .clk           (clk),
        .rstn          (rstn),
        .start_cnn     (start_cnn),
        .image_tvalid  (image_tvalid),
        .image_tdata   (image_tdata),
        .image_tready  (image_tready),
        .weight_tvalid (weight_tvalid),
        .weight_tdata  (weight_tdata),
        .weight_tready (weight_tready),
        .cnn_done      (cnn_done),
        .result_tvalid (result_tvalid),
        .result_tdata  (result_tdata)
    );

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    function automatic logic draw_valid();
        return ($random(seed) & 15) != 0;  // roughly one idle cycle in 16
    endfunction

    // stream bit n is bit n%25 of kernel word n/25
    function automatic logic weight_bit(input int n);
        logic [31:0] word;
        word = pattern[AW'(n / cnn_pkg::TAPS)];
        return word[5'(n % cnn_pkg::TAPS)];
    endfunction

    task automatic send_stream(input bit is_image, input int count);
        int   sent;
        logic taken;
        sent = 0;
        while (sent < count) begin
            if (is_image) begin
                if (!image_tvalid)
                    image_tvalid = draw_valid();
                image_tdata = pattern[AW'(N_KERN + sent)];
            end else begin
                if (!weight_tvalid)
                    weight_tvalid = draw_valid();
                weight_tdata = weight_bit(sent);
            end
            @(negedge clk);
            taken = is_image ? (image_tvalid && image_tready) : (weight_tvalid && weight_tready);
            @(posedge clk);
            #1;
            if (taken) begin
                sent++;
                if (is_image)
                    image_tvalid = 1'b0;
                else
                    weight_tvalid = 1'b0;
            end
        end
    endtask

    task automatic run_once();
        run_no++;
        start_cnn = 1'b1;
        @(posedge clk);
        #1;
        start_cnn = 1'b0;
        send_stream(1'b0, N_W);
        send_stream(1'b1, N_PIX);
        wait (done_count == 1);
        repeat (3) @(posedge clk);
        #1;
    endtask

    // everything is sampled mid-cycle, a handshake seen here completes on the next edge
    always @(negedge clk) begin
        if (rstn) begin
            if (seen_run != run_no) begin
                seen_run   = run_no;
                w_count    = 0;
                res_count  = 0;
                burst      = 0;
                done_count = 0;
            end
            if (run_no == 0) begin
                check_value("weight_tready before start", 0, 32'(weight_tready));
                check_value("image_tready before start", 0, 32'(image_tready));
                check_value("result_tvalid before start", 0, 32'(result_tvalid));
                check_value("cnn_done before start", 0, 32'(cnn_done));
            end
            if (w_count > 0 && w_count < N_W)
                check_value("weight_tready during weight load", 1, 32'(weight_tready));
            if (w_count >= N_W)
                check_value("weight_tready after last weight", 0, 32'(weight_tready));
            if (image_tready)
                check_value("weights taken before image_tready", N_W, w_count);
            if (weight_tvalid && weight_tready)
                w_count++;
            if (result_tvalid) begin
                check_value("image transfer during results", 0,
                            32'(image_tvalid && image_tready));
                if (res_count < N_RES)
                    check_value($sformatf("run %0d result %0d", run_no, res_count),
                                pattern[AW'(EXP_BASE + res_count)], result_tdata);
                else
                    check_value("results per run", N_RES, res_count + 1);
                res_count++;
                res_total++;
                burst++;
            end else if (burst != 0) begin
                check_value("valid cycles per window", N_KERN, burst);
                burst = 0;
            end
            if (cnn_done) begin
                check_value("results before cnn_done", N_RES, res_count);
                check_value("cnn_done pulses per run", 0, done_count);
                done_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run not finished within %0d cycles, %0d errors so far",
                     LIMIT, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        seed          = 91;
        rstn          = 1'b0;
        start_cnn     = 1'b0;
        weight_tvalid = 1'b0;
        weight_tdata  = 1'b0;
        image_tvalid  = 1'b0;
        image_tdata   = '0;
        $readmemh("testbench/cnn_patterns.mem", pattern);
        repeat (3) @(posedge clk);
        #1;  // inputs move just after the edge
        rstn = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        run_once();
        run_once();  // same patterns again after a fresh start edge
        $display("summary: %0d results checked over %0d runs, %0d errors",
                 res_total, run_no, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* cnn_conv.f */
rtl/cnn_pkg.sv
rtl/cnn_ctrl.sv
rtl/cnn_counter.sv
rtl/weight_bank.sv
rtl/line_window.sv
rtl/conv_kernel.sv
rtl/result_serializer.sv
rtl/cnn_top.sv
testbench/tb_clock.sv
testbench/tb_cnn.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_cnn -Mdir obj_dir -f cnn_conv.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_cnn)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

/* testbench/cnn_patterns.mem */
// 6 kernel words (bit j weights tap j), 36 pixels in raster order,
// then 24 expected results, window by window and kernel 0 to 5 inside each
01FFFFFF 00000000 00001FFF 01555555 00108421 01000000
// pixel = 8*row + col - 20, except 98 at row 2 col 2
FFFFFFEC FFFFFFED FFFFFFEE FFFFFFEF FFFFFFF0 FFFFFFF1
FFFFFFF4 FFFFFFF5 FFFFFFF6 FFFFFFF7 FFFFFFF8 FFFFFFF9
FFFFFFFC FFFFFFFD 00000062 FFFFFFFF 00000000 00000001
00000004 00000005 00000006 00000007 00000008 00000009
0000000C 0000000D 0000000E 0000000F 00000010 00000011
00000014 00000015 00000016 00000017 00000018 00000019
// windows ending at (4,4) (4,5) (5,4) (5,5)
00000032 FFFFFFCE FFFFFF6C 00000062 FFFFFFA6 FFFFFFEE
0000004B FFFFFFB5 FFFFFF6D FFFFFF9B FFFFFF97 FFFFFFD7
000000FA FFFFFF06 FFFFFF74 FFFFFFA2 FFFFFF2E FFFFFF36
00000113 FFFFFEED FFFFFF75 0000006B FFFFFF1F FFFFFF1F
